// File: Makefile
TOP = tb_nn_layer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: dv/tb_nn_layer.sv
`timescale 1ns/1ps

module tb_nn_layer;

	localparam int IN_CREDITS   = 4;
	localparam int NUM_SAMPLES  = 22;
	localparam int LINE_WORDS   = nn_pkg::NUM_IN + nn_pkg::NUM_NODES;
	localparam int HOLD_CYCLES  = 200;
	localparam int WATCH_CYCLES = 400 * (2 + 2 * NUM_SAMPLES);

	logic clk;
	logic arst_n;
	logic in_valid;
	logic [nn_pkg::FP_W-1:0] in_data;
	logic in_credit;
	logic out_valid;
	logic [nn_pkg::FP_W-1:0] out_data;
	logic out_credit;

	logic [nn_pkg::FP_W-1:0] tdata [NUM_SAMPLES*LINE_WORDS];
	logic [nn_pkg::FP_W-1:0] send_q [$];
	logic [nn_pkg::FP_W-1:0] exp_q [$];
	logic [nn_pkg::FP_W-1:0] expected;
	logic [31:0] rnd_state = 32'h2fcb;
	int snd_credits = IN_CREDITS;
	int outstanding = 0;
	int gap = 0;
	int out_index = 0;
	int errors = 0;
	int credit_errors = 0;
	int err_start = 0;
	int held_words = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	// 0 generous, 1 withhold, 2 random release
	int rcv_mode = 0;

	nn_layer_top u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_credit(out_credit)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ========================================
	// helpers
	// ========================================
	task automatic queue_sample(input int s);
		for (int k = 0; k < nn_pkg::NUM_IN; k++)
			send_q.push_back(tdata[s*LINE_WORDS + k]);
		for (int k = 0; k < nn_pkg::NUM_NODES; k++)
			exp_q.push_back(tdata[s*LINE_WORDS + nn_pkg::NUM_IN + k]);
	endtask

	task automatic wait_for_outputs();
		while (exp_q.size() != 0)
			@(posedge clk);
		// every input word has been popped by now
		assert (snd_credits == IN_CREDITS)
		else
		begin
			$display("FAIL %0t: sender holds %0d credits when idle, expected %0d",
				$time, snd_credits, IN_CREDITS);
			credit_errors++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		if (errs == 0)
		begin
			$display("test %0d %s: passed", num, name);
			tests_passed++;
		end
		else
		begin
			$display("test %0d %s: failed with %0d errors", num, name, errs);
			tests_failed++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// sender with its own credit count
	initial
	begin
		in_valid = 1'b0;
		in_data = '0;
		forever
		begin
			@(posedge clk);
			#1;
			if (in_credit)
				snd_credits++;
			if (send_q.size() != 0 && snd_credits > 0)
			begin
				in_valid = 1'b1;
				in_data = send_q.pop_front();
				snd_credits--;
			end
			else
				in_valid = 1'b0;
			assert (snd_credits >= 0 && snd_credits <= IN_CREDITS)
			else
			begin
				$display("FAIL %0t: sender credit count %0d out of range", $time, snd_credits);
				credit_errors++;
			end
		end
	end

	// receiver that checks data and issues credits
	initial
	begin
		out_credit = 1'b0;
		// no credits while the DUT is in reset
		wait (arst_n === 1'b1);
		forever
		begin
			@(posedge clk);
			#1;
			if (out_valid)
			begin
				assert (outstanding > 0)
				else
				begin
					$display("output word sent at %0t without a downstream credit", $time);
					errors++;
				end
				outstanding--;
				assert (exp_q.size() != 0)
				else
				begin
					$display("unexpected output word %h at %0t", out_data, $time);
					errors++;
				end
				if (exp_q.size() != 0)
				begin
					expected = exp_q.pop_front();
					assert (out_data == expected)
					else
					begin
						$display("FAIL %0t: output word %0d is %h, expected %h",
							$time, out_index, out_data, expected);
						errors++;
					end
				end
				out_index++;
			end
			out_credit = 1'b0;
			if (rcv_mode == 0 && outstanding < 8)
			begin
				out_credit = 1'b1;
				outstanding++;
			end
			else if (rcv_mode == 2)
			begin
				if (gap == 0)
				begin
					out_credit = 1'b1;
					outstanding++;
					rnd_state = lcg_step(rnd_state);
					gap = int'(rnd_state[18:16]);
				end
				else
					gap--;
			end
		end
	end

	initial
	begin
		repeat (WATCH_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCH_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ========================================
	// test sequence
	// ========================================
	initial
	begin
		arst_n = 1'b0;
		$readmemh("dv/testdata_nn_layer.txt", tdata);
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		err_start = errors;
		queue_sample(0);
		wait_for_outputs();
		report_test(1, "single sample", errors - err_start);

		err_start = errors;
		queue_sample(1);
		wait_for_outputs();
		report_test(2, "negative sums", errors - err_start);

		err_start = errors;
		for (int s = 0; s < NUM_SAMPLES; s++)
			queue_sample(s);
		wait_for_outputs();
		report_test(3, "streamed samples", errors - err_start);

		err_start = errors;
		rcv_mode = 1;
		for (int s = 0; s < NUM_SAMPLES; s++)
			queue_sample(s);
		repeat (HOLD_CYCLES) @(posedge clk);
		held_words = send_q.size();
		repeat (HOLD_CYCLES / 4) @(posedge clk);
		// with output credits withheld the input side has stopped taking words
		assert (held_words > 0 && send_q.size() == held_words)
		else
		begin
			$display("the input side kept accepting words under output back-pressure");
			errors++;
		end
		rcv_mode = 2;
		wait_for_outputs();
		rcv_mode = 0;
		report_test(4, "output back-pressure", errors - err_start);

		report_test(5, "input credit accounting", credit_errors);

		$display("tests passed: %0d, failed: %0d, errors: %0d",
			tests_passed, tests_failed, errors + credit_errors);
		if (tests_failed == 0 && errors + credit_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: dv/testdata_nn_layer.txt
// each line: 15 input words, then the expected outputs of nodes 0 to 3
// all words are IEEE single precision in hex
3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3ea7926c 3f000000 00000000 3f800000
00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3e93cf67 00000000 00000000 00000000
00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f03c68b 3e800000 3e19999a 3f000000
00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f178106 3f400000 00000000 00000000
00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3e490114 00000000 00000000 3e800000
00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3e000000 3d4ccccd 00000000
00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3eefabd7 00000000 00000000 3e000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f200000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3e99999a 3d800000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 3ea00000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 3e46b12f 00000000 00000000 3f400000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 3dcccccd 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 3e4ccccd 3ec00000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 3ebcc8b2 3f333333 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 3f000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bf800000 00000000 00000000 00000000 3f1d9b8a 00000000 3e4ccccd 3f400000
40000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f27926c 3f800000 00000000 40000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f000000 00000000 3e3cc8b2 3eb33333 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 c0000000 00000000 00000000 00000000 00000000 00000000 00000000 3f5c760e 3f400000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 40800000 00000000 00000000 00000000 00000000 00000000 00000000 3fa00000 00000000 00000000
3f800000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f1db0e9 3e800000 00000000 00000000
00000000 00000000 3f800000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f8da3c8 3f800000 00000000 00000000

// File: hdl/float_adder.sv
`timescale 1ns/1ps

module float_adder (
	input  logic [nn_pkg::FP_W-1:0] a,
	input  logic [nn_pkg::FP_W-1:0] b,
	output logic [nn_pkg::FP_W-1:0] sum
);

	logic [nn_pkg::FP_W-1:0] op_hi;
	logic [nn_pkg::FP_W-1:0] op_lo;
	logic [23:0] mant_hi;
	logic [23:0] mant_lo;
	logic [23:0] mant_shift;
	logic [24:0] mant_sum;
	logic [23:0] mant_norm;
	logic [7:0] exp_diff;
	logic [4:0] lead_zeros;
	logic found;
	logic signed [9:0] exp_res;
	logic [22:0] frac;

	always_comb
	begin
		// order by magnitude, sign bit left out of the compare
		if (a[30:0] >= b[30:0])
		begin
			op_hi = a;
			op_lo = b;
		end
		else
		begin
			op_hi = b;
			op_lo = a;
		end

		mant_hi = (op_hi[30:23] == 8'd0) ? 24'd0 : {1'b1, op_hi[22:0]};
		mant_lo = (op_lo[30:23] == 8'd0) ? 24'd0 : {1'b1, op_lo[22:0]};

		// bits shifted out of the smaller operand are simply lost
		exp_diff = op_hi[30:23] - op_lo[30:23];
		mant_shift = mant_lo >> exp_diff;

		if (op_hi[31] == op_lo[31])
			mant_sum = {1'b0, mant_hi} + {1'b0, mant_shift};
		else
			mant_sum = {1'b0, mant_hi} - {1'b0, mant_shift};

		// leading zero count over the 24 bit field
		lead_zeros = 5'd0;
		found = 1'b0;
		for (int i = 23; i >= 0; i--)
		begin
			if (!found)
			begin
				if (mant_sum[i])
					found = 1'b1;
				else
					lead_zeros = lead_zeros + 5'd1;
			end
		end
		mant_norm = mant_sum[23:0] << lead_zeros;

		if (mant_sum[24])
		begin
			exp_res = $signed({2'b00, op_hi[30:23]}) + 10'sd1;
			frac = mant_sum[23:1];
		end
		else
		begin
			exp_res = $signed({2'b00, op_hi[30:23]}) - $signed({5'd0, lead_zeros});
			frac = mant_norm[22:0];
		end

		// exact cancellation lands here too, always as +0
		if (mant_sum == 25'd0 || exp_res <= 10'sd0)
			sum = '0;
		else if (exp_res >= 10'sd255)
			sum = {op_hi[31], 8'hfe, 23'h7fffff};
		else
			sum = {op_hi[31], exp_res[7:0], frac};
	end

endmodule

// File: hdl/float_mult.sv
`timescale 1ns/1ps

module float_mult (
	input  logic [nn_pkg::FP_W-1:0] x,
	input  logic [nn_pkg::FP_W-1:0] y,
	output logic [nn_pkg::FP_W-1:0] z
);

	logic [23:0] mant_x;
	logic [23:0] mant_y;
	logic [47:0] mant_p;
	logic [22:0] frac;
	logic signed [9:0] exp_z;
	logic sign_z;
	logic zero_in;

	always_comb
	begin
		sign_z = x[31] ^ y[31];
		// exponent zero covers both zero and denormal operands
		zero_in = (x[30:23] == 8'd0) || (y[30:23] == 8'd0);
		mant_x = {1'b1, x[22:0]};
		mant_y = {1'b1, y[22:0]};
		mant_p = mant_x * mant_y;

		// product of two 1.x mantissas is below 4, so one bit of normalisation
		exp_z = $signed({2'b00, x[30:23]}) + $signed({2'b00, y[30:23]}) - 10'sd127
			+ $signed({9'd0, mant_p[47]});

		if (mant_p[47])
			frac = mant_p[46:24];
		else
			frac = mant_p[45:23];

		if (zero_in || exp_z <= 10'sd0)
			z = '0;
		else if (exp_z >= 10'sd255)
			z = {sign_z, 8'hfe, 23'h7fffff};
		else
			z = {sign_z, exp_z[7:0], frac};
	end

endmodule

// File: hdl/input_collector.sv
`timescale 1ns/1ps

module input_collector (
	input  logic clk,
	input  logic arst_n,
	input  logic in_valid,
	input  logic [nn_pkg::FP_W-1:0] in_data,
	output logic in_credit,
	input  logic slot_free,
	output logic vec_valid,
	output logic [nn_pkg::NUM_IN-1:0][nn_pkg::FP_W-1:0] vec_data
);

	typedef logic [$clog2(nn_pkg::IN_CREDITS)-1:0] ptr_t;
	typedef logic [$clog2(nn_pkg::IN_CREDITS+1)-1:0] cnt_t;
	typedef logic [$clog2(nn_pkg::NUM_IN)-1:0] idx_t;
	typedef logic [$clog2(nn_pkg::OUT_DEPTH+1)-1:0] rsv_t;

	logic [nn_pkg::FP_W-1:0] fifo_mem [nn_pkg::IN_CREDITS];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t fifo_cnt;
	idx_t word_idx;
	rsv_t reserved;
	nn_pkg::collect_state_e state;
	logic pop;
	logic last_word;
	logic launch;

	// no popping while a finished sample waits for output room
	assign pop = (fifo_cnt != '0) && (state != nn_pkg::LAUNCH);
	assign last_word = (word_idx == idx_t'(nn_pkg::NUM_IN - 1));
	assign launch = (state == nn_pkg::LAUNCH)
		&& (int'(reserved) + nn_pkg::NUM_NODES <= nn_pkg::OUT_DEPTH);

	always_ff @(posedge clk)
	begin
		if (in_valid)
			fifo_mem[wr_ptr] <= in_data;
		if (pop)
			vec_data[word_idx] <= fifo_mem[rd_ptr];
	end

	// ========================================
	// buffer pointers, credits, reservation
	// ========================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			in_credit <= 1'b0;
			vec_valid <= 1'b0;
			reserved <= '0;
			word_idx <= '0;
			state <= nn_pkg::IDLE;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fifo_cnt <= fifo_cnt + cnt_t'(in_valid) - cnt_t'(pop);
			// a credit goes back for every word that leaves the buffer
			in_credit <= pop;
			vec_valid <= launch;
			reserved <= reserved + (launch ? rsv_t'(nn_pkg::NUM_NODES) : '0) - rsv_t'(slot_free);

			if (pop)
				word_idx <= last_word ? '0 : word_idx + 1'b1;

			case (state)
				nn_pkg::IDLE:
				begin
					if (pop)
						state <= nn_pkg::GATHER;
				end
				nn_pkg::GATHER:
				begin
					if (pop && last_word)
						state <= nn_pkg::LAUNCH;
				end
				nn_pkg::LAUNCH:
				begin
					if (launch)
						state <= nn_pkg::IDLE;
				end
				default:
					state <= nn_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: hdl/neuron_node.sv
`timescale 1ns/1ps

module neuron_node #(
	parameter int NODE = 0
) (
	input  logic clk,
	input  logic arst_n,
	input  logic vec_valid,
	input  logic [nn_pkg::NUM_IN-1:0][nn_pkg::FP_W-1:0] vec_data,
	output logic res_valid,
	output logic [nn_pkg::FP_W-1:0] res_data
);

	logic [nn_pkg::FP_W-1:0] prod [nn_pkg::NUM_IN];
	logic [nn_pkg::FP_W-1:0] prod_q [nn_pkg::NUM_IN];
	logic [nn_pkg::FP_W-1:0] lvl1 [7];
	logic [nn_pkg::FP_W-1:0] lvl1_q [8];
	logic [nn_pkg::FP_W-1:0] lvl2 [4];
	logic [nn_pkg::FP_W-1:0] lvl2_q [4];
	logic [nn_pkg::FP_W-1:0] lvl3 [2];
	logic [nn_pkg::FP_W-1:0] lvl3_q [2];
	logic [nn_pkg::FP_W-1:0] lvl4;
	logic [nn_pkg::PIPE_LAT-1:0] vld_q;

	genvar i;

	generate
		for (i = 0; i < nn_pkg::NUM_IN; i++)
		begin : g_mult
			float_mult u_mult (
				.x(vec_data[i]),
				.y(nn_pkg::WEIGHTS[NODE][i]),
				.z(prod[i])
			);
		end

		// ========================================
		// adder tree
		// ========================================
		// products 0..13 pair up, product 14 joins at level two
		for (i = 0; i < 7; i++)
		begin : g_lvl1
			float_adder u_add (.a(prod_q[2*i]), .b(prod_q[2*i+1]), .sum(lvl1[i]));
		end

		for (i = 0; i < 4; i++)
		begin : g_lvl2
			float_adder u_add (.a(lvl1_q[2*i]), .b(lvl1_q[2*i+1]), .sum(lvl2[i]));
		end

		for (i = 0; i < 2; i++)
		begin : g_lvl3
			float_adder u_add (.a(lvl2_q[2*i]), .b(lvl2_q[2*i+1]), .sum(lvl3[i]));
		end
	endgenerate

	float_adder u_add_final (.a(lvl3_q[0]), .b(lvl3_q[1]), .sum(lvl4));

	always_ff @(posedge clk)
	begin
		prod_q <= prod;
		for (int k = 0; k < 7; k++)
			lvl1_q[k] <= lvl1[k];
		lvl1_q[7] <= prod_q[nn_pkg::NUM_IN-1];
		lvl2_q <= lvl2;
		lvl3_q <= lvl3;
		// relu
		res_data <= lvl4[nn_pkg::FP_W-1] ? '0 : lvl4;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vld_q <= '0;
		else
			vld_q <= {vld_q[nn_pkg::PIPE_LAT-2:0], vec_valid};
	end

	assign res_valid = vld_q[nn_pkg::PIPE_LAT-1];

endmodule

// File: hdl/nn_layer_top.sv
`timescale 1ns/1ps

module nn_layer_top (
	input  logic clk,
	input  logic arst_n,
	input  logic in_valid,
	input  logic [nn_pkg::FP_W-1:0] in_data,
	output logic in_credit,
	output logic out_valid,
	output logic [nn_pkg::FP_W-1:0] out_data,
	input  logic out_credit
);

	logic vec_valid;
	logic [nn_pkg::NUM_IN-1:0][nn_pkg::FP_W-1:0] vec_data;
	logic [nn_pkg::NUM_NODES-1:0] res_valid;
	logic [nn_pkg::NUM_NODES-1:0][nn_pkg::FP_W-1:0] res_data;
	logic slot_free;

	input_collector u_collector (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_credit(in_credit),
		.slot_free(slot_free),
		.vec_valid(vec_valid),
		.vec_data(vec_data)
	);

	// all neurons see the same sample, each with its own weight row
	genvar n;
	generate
		for (n = 0; n < nn_pkg::NUM_NODES; n++)
		begin : g_node
			neuron_node #(
				.NODE(n)
			) u_node (
				.clk(clk),
				.arst_n(arst_n),
				.vec_valid(vec_valid),
				.vec_data(vec_data),
				.res_valid(res_valid[n]),
				.res_data(res_data[n])
			);
		end
	endgenerate

	output_serializer u_serializer (
		.clk(clk),
		.arst_n(arst_n),
		.res_valid(res_valid),
		.res_data(res_data),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_credit(out_credit),
		.slot_free(slot_free)
	);

endmodule

// File: hdl/nn_pkg.sv
package nn_pkg;

	localparam int FP_W       = 32;
	localparam int NUM_IN     = 15;
	localparam int NUM_NODES  = 4;
	localparam int IN_CREDITS = 4;
	// result buffer holds four samples
	localparam int OUT_DEPTH  = 16;
	// multiplier register plus four adder tree levels
	localparam int PIPE_LAT   = 5;

	// ========================================
	// weight table, one row per neuron
	// ========================================
	localparam logic [FP_W-1:0] WEIGHTS [NUM_NODES][NUM_IN] = '{
		'{
			32'h3ea7926c, 32'h3e93cf67, 32'h3f03c68b, 32'h3f178106, 32'h3e490114,
			32'hbcad29e0, 32'h3eefabd7, 32'hbe84a3cd, 32'hbedc760e, 32'hbed26dfd,
			32'h3e46b12f, 32'hbf1d9b8a, 32'hbc859605, 32'h3ebcc8b2, 32'hbec6bf92
		},
		'{
			32'h3f000000, 32'hbe800000, 32'h3e800000, 32'h3f400000, 32'hbf000000,
			32'h3e000000, 32'hbe000000, 32'h3f200000, 32'hbec00000, 32'h3ea00000,
			32'hbf100000, 32'h3dcccccd, 32'hbdcccccd, 32'h3f333333, 32'hbe4ccccd
		},
		// mostly negative row
		'{
			32'hbf000000, 32'hbe99999a, 32'h3e19999a, 32'hbf19999a, 32'hbe800000,
			32'h3d4ccccd, 32'hbf4ccccd, 32'hbe000000, 32'h3e99999a, 32'hbf000000,
			32'hbdcccccd, 32'hbe4ccccd, 32'h3e4ccccd, 32'hbf333333, 32'hbe800000
		},
		'{
			32'h3f800000, 32'hbf800000, 32'h3f000000, 32'hbf000000, 32'h3e800000,
			32'hbe800000, 32'h3e000000, 32'hbe000000, 32'h3d800000, 32'hbd800000,
			32'h3f400000, 32'hbf400000, 32'h3ec00000, 32'hbec00000, 32'h3f000000
		}
	};

	typedef enum logic [1:0] {
		IDLE,
		GATHER,
		LAUNCH
	} collect_state_e;

endpackage

// File: hdl/output_serializer.sv
`timescale 1ns/1ps

module output_serializer (
	input  logic clk,
	input  logic arst_n,
	input  logic [nn_pkg::NUM_NODES-1:0] res_valid,
	input  logic [nn_pkg::NUM_NODES-1:0][nn_pkg::FP_W-1:0] res_data,
	output logic out_valid,
	output logic [nn_pkg::FP_W-1:0] out_data,
	input  logic out_credit,
	output logic slot_free
);

	typedef logic [$clog2(nn_pkg::OUT_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(nn_pkg::OUT_DEPTH+1)-1:0] cnt_t;
	typedef logic [15:0] cred_t;

	logic [nn_pkg::FP_W-1:0] buf_mem [nn_pkg::OUT_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	ptr_t wr_addr [nn_pkg::NUM_NODES];
	cnt_t buf_cnt;
	cnt_t wr_num;
	cred_t credit_cnt;
	logic send;

	// results of one sample packed into consecutive slots, node 0 first
	always_comb
	begin
		wr_num = '0;
		for (int k = 0; k < nn_pkg::NUM_NODES; k++)
		begin
			wr_addr[k] = wr_ptr + ptr_t'(wr_num);
			if (res_valid[k])
				wr_num = wr_num + 1'b1;
		end
	end

	assign send = (buf_cnt != '0) && (credit_cnt != '0);

	always_ff @(posedge clk)
	begin
		for (int k = 0; k < nn_pkg::NUM_NODES; k++)
		begin
			if (res_valid[k])
				buf_mem[wr_addr[k]] <= res_data[k];
		end
		if (send)
			out_data <= buf_mem[rd_ptr];
	end

	// ========================================
	// pointers and downstream credits
	// ========================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			buf_cnt <= '0;
			credit_cnt <= '0;
			out_valid <= 1'b0;
			slot_free <= 1'b0;
		end
		else
		begin
			wr_ptr <= wr_ptr + ptr_t'(wr_num);
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			buf_cnt <= buf_cnt + wr_num - cnt_t'(send);
			credit_cnt <= credit_cnt + cred_t'(out_credit) - cred_t'(send);
			out_valid <= send;
			// slot released back to the collector's reservation
			slot_free <= send;
		end
	end

endmodule

// File: sources.f
hdl/nn_pkg.sv
hdl/float_mult.sv
hdl/float_adder.sv
hdl/neuron_node.sv
hdl/input_collector.sv
hdl/output_serializer.sv
hdl/nn_layer_top.sv
dv/tb_nn_layer.sv
